/* rv_pkg.sv */
package rv_pkg;

    // major opcodes handled by this slice
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_opimm  = 7'b0010011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_system = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_xor,
        alu_or, alu_and, alu_sll, alu_srl, alu_sra
    } alu_op_type;

    typedef enum logic [2:0] {
        bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu
    } bcu_op_type;

    // mcause codes
    typedef logic [3:0] ecause_type;
    localparam ecause_type except_illegal_instruction = 4'd2;
    localparam ecause_type except_breakpoint          = 4'd3;
    localparam ecause_type except_env_call_mach       = 4'd11;

    typedef struct packed {
        logic [31:0] imm;
        logic        wren;
        logic        rden1;
        logic        rden2;
        logic        lui;
        logic        auipc;
        logic        jal;
        logic        jalr;
        logic        branch;
        alu_op_type  alu_op;
        bcu_op_type  bcu_op;
        logic        imm_sel; // second alu operand is imm
        logic        ecall;
        logic        ebreak;
        logic        valid;
    } decoder_out_type;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] npc;
        logic [4:0]  waddr;
        logic        wren;
        logic        jump;
        logic [31:0] jump_target;
        logic [31:0] rdata1;
        logic [31:0] rdata2;
        logic [31:0] imm;
        logic        lui;
        logic        auipc;
        logic        jal;
        logic        jalr;
        logic        imm_sel;
        alu_op_type  alu_op;
        logic        valid;
        logic        exception;
        ecause_type  ecause;
        logic [31:0] etval;
    } decode_reg_type;

    localparam decode_reg_type init_decode_reg = '{alu_op: alu_add, default: '0};

endpackage

/* rv_stage_if.sv */
interface rv_stage_if;

    rv_pkg::decode_reg_type q;
    logic                   q_valid;

    // combinational result of the item in q
    logic                   exe_wren;
    logic [4:0]             exe_waddr;
    logic [31:0]            exe_result;

    // registered result, one cycle older
    logic                   res_wren;
    logic [4:0]             res_waddr;
    logic [31:0]            res_data;

    modport decode (
        output q, q_valid,
        input  exe_wren, exe_waddr, exe_result,
        input  res_wren, res_waddr, res_data
    );

    modport execute (
        input  q, q_valid,
        output exe_wren, exe_waddr, exe_result,
        output res_wren, res_waddr, res_data
    );

endinterface

/* rv_decoder.sv */
module rv_decoder (
    input  logic [31:0]             instr,
    output rv_pkg::decoder_out_type dec
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [31:0]        imm_i;
    logic [31:0]        imm_b;
    logic [31:0]        imm_u;
    logic [31:0]        imm_j;
    logic               f7_zero;
    logic               f7_alt;
    rv_pkg::alu_op_type alu_sel;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // shared by register and immediate forms, sub is picked in the OP branch
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = rv_pkg::alu_add;
            3'b001:  alu_sel = rv_pkg::alu_sll;
            3'b010:  alu_sel = rv_pkg::alu_slt;
            3'b011:  alu_sel = rv_pkg::alu_sltu;
            3'b100:  alu_sel = rv_pkg::alu_xor;
            3'b101:  alu_sel = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  alu_sel = rv_pkg::alu_or;
            default: alu_sel = rv_pkg::alu_and;
        endcase
    end

    always_comb begin
        dec = '0;
        dec.alu_op = rv_pkg::alu_add;
        dec.bcu_op = rv_pkg::bcu_beq;
        case (opcode)
            rv_pkg::opcode_op: begin
                dec.wren   = 1'b1;
                dec.rden1  = 1'b1;
                dec.rden2  = 1'b1;
                dec.alu_op = (funct3 == 3'b000 && funct7[5]) ? rv_pkg::alu_sub : alu_sel;
                dec.valid  = f7_zero | (f7_alt & (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_pkg::opcode_opimm: begin
                dec.wren    = 1'b1;
                dec.rden1   = 1'b1;
                dec.imm_sel = 1'b1;
                dec.imm     = imm_i;
                dec.alu_op  = alu_sel;
                if (funct3 == 3'b001) begin
                    dec.valid = f7_zero; // slli
                end else if (funct3 == 3'b101) begin
                    dec.valid = f7_zero | f7_alt;
                end else begin
                    dec.valid = 1'b1;
                end
            end
            rv_pkg::opcode_lui: begin
                dec.wren  = 1'b1;
                dec.lui   = 1'b1;
                dec.imm   = imm_u;
                dec.valid = 1'b1;
            end
            rv_pkg::opcode_auipc: begin
                dec.wren  = 1'b1;
                dec.auipc = 1'b1;
                dec.imm   = imm_u;
                dec.valid = 1'b1;
            end
            rv_pkg::opcode_jal: begin
                dec.wren  = 1'b1;
                dec.jal   = 1'b1;
                dec.imm   = imm_j;
                dec.valid = 1'b1;
            end
            rv_pkg::opcode_jalr: begin
                dec.wren  = 1'b1;
                dec.rden1 = 1'b1;
                dec.jalr  = 1'b1;
                dec.imm   = imm_i;
                dec.valid = (funct3 == 3'b000);
            end
            rv_pkg::opcode_branch: begin
                dec.rden1  = 1'b1;
                dec.rden2  = 1'b1;
                dec.branch = 1'b1;
                dec.imm    = imm_b;
                case (funct3)
                    3'b000:  dec.bcu_op = rv_pkg::bcu_beq;
                    3'b001:  dec.bcu_op = rv_pkg::bcu_bne;
                    3'b100:  dec.bcu_op = rv_pkg::bcu_blt;
                    3'b101:  dec.bcu_op = rv_pkg::bcu_bge;
                    3'b110:  dec.bcu_op = rv_pkg::bcu_bltu;
                    default: dec.bcu_op = rv_pkg::bcu_bgeu;
                endcase
                dec.valid = (funct3[2:1] != 2'b01); // 010 and 011 are reserved
            end
            rv_pkg::opcode_system: begin
                // only ecall and ebreak, no csr access here
                dec.ecall  = (instr == 32'h00000073);
                dec.ebreak = (instr == 32'h00100073);
                dec.valid  = dec.ecall | dec.ebreak;
            end
            default: ;
        endcase
    end

endmodule

/* rv_regfile.sv */
module rv_regfile (
    input  logic        clock,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        wren,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    // entry 0 is never written and never read
    always_ff @(posedge clock) begin
        if (wren && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'h0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'h0 : regs[raddr2];

endmodule

/* rv_decode_stage.sv */
module rv_decode_stage #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  logic [31:0]             instr,
    input  logic [31:0]             pc,
    input  rv_pkg::decoder_out_type dec,
    output logic [4:0]              raddr1,
    output logic [4:0]              raddr2,
    input  logic [31:0]             rdata1,
    input  logic [31:0]             rdata2,
    rv_stage_if.decode              stage
);

    rv_pkg::decode_reg_type r;
    rv_pkg::decode_reg_type v;
    logic [31:0]            rs1;
    logic [31:0]            rs2;
    logic                   taken;
    logic                   flush;

    // newest producer wins, x0 is never forwarded
    function automatic logic [31:0] forward(input logic rden, input logic [4:0] addr,
                                            input logic [31:0] rf_data);
        if (!rden || addr == 5'd0) begin
            return 32'h0;
        end else if (stage.exe_wren && stage.exe_waddr == addr) begin
            return stage.exe_result;
        end else if (stage.res_wren && stage.res_waddr == addr) begin
            return stage.res_data;
        end else begin
            return rf_data;
        end
    endfunction

    assign raddr1 = instr[19:15];
    assign raddr2 = instr[24:20];

    assign rs1 = forward(dec.rden1, raddr1, rdata1);
    assign rs2 = forward(dec.rden2, raddr2, rdata2);

    always_comb begin
        case (dec.bcu_op)
            rv_pkg::bcu_beq:  taken = (rs1 == rs2);
            rv_pkg::bcu_bne:  taken = (rs1 != rs2);
            rv_pkg::bcu_blt:  taken = ($signed(rs1) < $signed(rs2));
            rv_pkg::bcu_bge:  taken = ($signed(rs1) >= $signed(rs2));
            rv_pkg::bcu_bltu: taken = (rs1 < rs2);
            rv_pkg::bcu_bgeu: taken = (rs1 >= rs2);
            default:          taken = 1'b0;
        endcase
    end

    assign flush = r.valid & r.jump; // kill the slot after a taken jump

    always_comb begin
        v = rv_pkg::init_decode_reg;
        v.pc          = pc;
        v.npc         = pc + 32'd4;
        v.waddr       = instr[11:7];
        v.wren        = dec.wren;
        v.jump        = dec.jal | dec.jalr | (dec.branch & taken);
        v.jump_target = dec.jalr ? ((rs1 + dec.imm) & ~32'h1) : (pc + dec.imm);
        v.rdata1      = rs1;
        v.rdata2      = rs2;
        v.imm         = dec.imm;
        v.lui         = dec.lui;
        v.auipc       = dec.auipc;
        v.jal         = dec.jal;
        v.jalr        = dec.jalr;
        v.imm_sel     = dec.imm_sel;
        v.alu_op      = dec.alu_op;
        v.valid       = 1'b1;

        if (!dec.valid) begin
            v.exception = 1'b1;
            v.ecause    = rv_pkg::except_illegal_instruction;
            v.etval     = instr;
        end else if (dec.ebreak) begin
            v.exception = 1'b1;
            v.ecause    = rv_pkg::except_breakpoint;
            v.etval     = instr;
        end else if (dec.ecall) begin
            v.exception = 1'b1;
            v.ecause    = rv_pkg::except_env_call_mach;
            v.etval     = instr;
        end

        // a trapping instruction neither writes back nor redirects
        if (v.exception) begin
            v.wren = 1'b0;
            v.jump = 1'b0;
        end

        if (!instr_valid || flush) begin
            v    = rv_pkg::init_decode_reg;
            v.pc = r.pc; // hold the last pc
        end
    end

    always_ff @(posedge clock) begin
        if (reset == 1'b0) begin
            r    <= rv_pkg::init_decode_reg;
            r.pc <= reset_pc;
        end else begin
            r <= v;
        end
    end

    assign stage.q       = r;
    assign stage.q_valid = r.valid;

endmodule

/* rv_execute_stage.sv */
module rv_execute_stage (
    input  logic               clock,
    input  logic               reset,
    rv_stage_if.execute        stage,
    output logic               rf_wren,
    output logic [4:0]         rf_waddr,
    output logic [31:0]        rf_wdata,
    output logic               res_valid,
    output logic               res_wren,
    output logic [4:0]         res_waddr,
    output logic [31:0]        res_data,
    output logic               res_jump,
    output logic [31:0]        res_target,
    output logic               res_exception,
    output rv_pkg::ecause_type res_ecause,
    output logic [31:0]        res_etval
);

    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] alu_result;
    logic [31:0] result;

    assign op1 = stage.q.rdata1;
    assign op2 = stage.q.imm_sel ? stage.q.imm : stage.q.rdata2;

    always_comb begin
        case (stage.q.alu_op)
            rv_pkg::alu_sub:  alu_result = op1 - op2;
            rv_pkg::alu_slt:  alu_result = {31'h0, $signed(op1) < $signed(op2)};
            rv_pkg::alu_sltu: alu_result = {31'h0, op1 < op2};
            rv_pkg::alu_xor:  alu_result = op1 ^ op2;
            rv_pkg::alu_or:   alu_result = op1 | op2;
            rv_pkg::alu_and:  alu_result = op1 & op2;
            rv_pkg::alu_sll:  alu_result = op1 << op2[4:0];
            rv_pkg::alu_srl:  alu_result = op1 >> op2[4:0];
            rv_pkg::alu_sra:  alu_result = $signed(op1) >>> op2[4:0];
            default:          alu_result = op1 + op2;
        endcase
    end

    always_comb begin
        if (stage.q.lui) begin
            result = stage.q.imm;
        end else if (stage.q.auipc) begin
            result = stage.q.pc + stage.q.imm;
        end else if (stage.q.jal || stage.q.jalr) begin
            result = stage.q.npc; // link address
        end else begin
            result = alu_result;
        end
    end

    assign stage.exe_wren   = stage.q_valid & stage.q.wren;
    assign stage.exe_waddr  = stage.q.waddr;
    assign stage.exe_result = result;

    always_ff @(posedge clock) begin
        if (reset == 1'b0) begin
            res_valid     <= 1'b0;
            res_wren      <= 1'b0;
            res_jump      <= 1'b0;
            res_exception <= 1'b0;
        end else begin
            res_valid     <= stage.q_valid;
            res_wren      <= stage.q_valid & stage.q.wren;
            res_jump      <= stage.q_valid & stage.q.jump;
            res_exception <= stage.q_valid & stage.q.exception;
        end
    end

    always_ff @(posedge clock) begin
        res_waddr  <= stage.q.waddr;
        res_data   <= result;
        res_target <= stage.q.jump_target;
        res_ecause <= stage.q.ecause;
        res_etval  <= stage.q.etval;
    end

    // result register feeds both forwarding and the register file
    assign stage.res_wren  = res_wren;
    assign stage.res_waddr = res_waddr;
    assign stage.res_data  = res_data;

    assign rf_wren  = res_wren;
    assign rf_waddr = res_waddr;
    assign rf_wdata = res_data;

endmodule

/* rv_core_top.sv */
module rv_core_top #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output logic        res_valid,
    output logic        res_wren,
    output logic [4:0]  res_waddr,
    output logic [31:0] res_data,
    output logic        res_jump,
    output logic [31:0] res_target,
    output logic        res_exception,
    output logic [3:0]  res_ecause,
    output logic [31:0] res_etval
);

    rv_pkg::decoder_out_type dec;
    logic [4:0]              raddr1;
    logic [4:0]              raddr2;
    logic [31:0]             rdata1;
    logic [31:0]             rdata2;
    logic                    rf_wren;
    logic [4:0]              rf_waddr;
    logic [31:0]             rf_wdata;

    rv_stage_if stage_if0 ();

    rv_decoder decoder0 (
        .instr (instr),
        .dec   (dec)
    );

    rv_regfile regfile0 (
        .clock  (clock),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wren   (rf_wren),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    rv_decode_stage #(
        .reset_pc (reset_pc)
    ) decode0 (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .dec         (dec),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .stage       (stage_if0.decode)
    );

    rv_execute_stage execute0 (
        .clock         (clock),
        .reset         (reset),
        .stage         (stage_if0.execute),
        .rf_wren       (rf_wren),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata),
        .res_valid     (res_valid),
        .res_wren      (res_wren),
        .res_waddr     (res_waddr),
        .res_data      (res_data),
        .res_jump      (res_jump),
        .res_target    (res_target),
        .res_exception (res_exception),
        .res_ecause    (res_ecause),
        .res_etval     (res_etval)
    );

endmodule

/* rv_core_tb.sv */
module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clock_period = 40;
    localparam int fields       = 10; // columns per row in the case file
    localparam int max_cases    = 64;

    logic        clock;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        res_valid;
    logic        res_wren;
    logic [4:0]  res_waddr;
    logic [31:0] res_data;
    logic        res_jump;
    logic [31:0] res_target;
    logic        res_exception;
    logic [3:0]  res_ecause;
    logic [31:0] res_etval;

    // entry 0 is the case count, then one row of fields per case
    logic [31:0] case_mem [0:fields*max_cases];
    int          num_cases;
    int          error_count;
    int          failed_tests;
    bit          loaded;

    rv_core_top #(
        .reset_pc (32'h0)
    ) dut0 (
        .clock         (clock),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .res_valid     (res_valid),
        .res_wren      (res_wren),
        .res_waddr     (res_waddr),
        .res_data      (res_data),
        .res_jump      (res_jump),
        .res_target    (res_target),
        .res_exception (res_exception),
        .res_ecause    (res_ecause),
        .res_etval     (res_etval)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic logic [31:0] case_field(input int row, input int col);
        return case_mem[1 + row * fields + col];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    // the word presented during reset must not come out
    task automatic expect_idle();
        int errors_before;
        errors_before = error_count;
        compare_value("res_valid", 32'(res_valid), 32'h0);
        compare_value("res_wren", 32'(res_wren), 32'h0);
        compare_value("res_jump", 32'(res_jump), 32'h0);
        compare_value("res_exception", 32'(res_exception), 32'h0);
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("idle after reset: %s", (error_count == errors_before) ? "ok" : "failed");
    endtask

    task automatic score_case(input int row);
        int          errors_before;
        logic [31:0] exp_wren;
        logic [31:0] exp_jump;
        logic [31:0] exp_exception;
        errors_before = error_count;
        exp_wren      = case_field(row, 3);
        exp_jump      = case_field(row, 6);
        exp_exception = case_field(row, 8);
        compare_value("res_valid", 32'(res_valid), case_field(row, 2));
        compare_value("res_wren", 32'(res_wren), exp_wren);
        compare_value("res_jump", 32'(res_jump), exp_jump);
        compare_value("res_exception", 32'(res_exception), exp_exception);
        if (exp_wren != 32'h0) begin
            compare_value("res_waddr", 32'(res_waddr), case_field(row, 4));
            compare_value("res_data", res_data, case_field(row, 5));
        end
        if (exp_jump != 32'h0) begin
            compare_value("res_target", res_target, case_field(row, 7));
        end
        if (exp_exception != 32'h0) begin
            compare_value("res_ecause", 32'(res_ecause), case_field(row, 9));
            compare_value("res_etval", res_etval, case_field(row, 1)); // the trapping word
        end
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("case %0d pc %h instr %h: %s", row, case_field(row, 0), case_field(row, 1),
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int slot;
        clock        = 1'b0;
        reset        = 1'b0;
        instr_valid  = 1'b0;
        instr        = 32'h0;
        pc           = 32'h0;
        error_count  = 0;
        failed_tests = 0;
        void'($urandom(25359));

        $readmemh("rv_cases.txt", case_mem);
        num_cases = int'(case_mem[0]);
        loaded    = 1'b1;

        if (num_cases < 1 || num_cases > max_cases) begin
            $display("could not load a usable case count from rv_cases.txt (%0d)", num_cases);
            error_count++;
        end else begin
            @(posedge clock);
            pc          <= case_field(0, 0);
            instr       <= case_field(0, 1); // valid word held while reset is active
            instr_valid <= 1'b1;
            @(posedge clock);
            reset       <= 1'b1;
            instr_valid <= 1'b0;
            @(posedge clock);
            @(negedge clock);
            expect_idle();

            // results come out two edges after the drive and are sampled at the falling edge
            for (slot = 0; slot < num_cases + 2; slot++) begin
                @(posedge clock);
                if (slot < num_cases) begin
                    pc          <= case_field(slot, 0);
                    instr       <= case_field(slot, 1);
                    instr_valid <= 1'b1;
                end else begin
                    pc          <= $urandom;
                    instr       <= $urandom; // ignored in an idle slot
                    instr_valid <= 1'b0;
                end
                @(negedge clock);
                if (slot >= 2) begin
                    score_case(slot - 2);
                end
            end
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 num_cases + 1, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((num_cases + 10) * clock_period);
        $display("watchdog expired: the cases did not finish in the expected time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* rv_cases.txt */
// first value is the number of cases, then one case per line:
// pc instr valid wren waddr data jump target exception ecause
1c
00000100 00500093 1 1 01 00000005 0 00000000 0 0
00000104 ffd00113 1 1 02 fffffffd 0 00000000 0 0
00000108 123451b7 1 1 03 12345000 0 00000000 0 0
0000010c 00700013 1 1 00 00000007 0 00000000 0 0
00000110 00100233 1 1 04 00000005 0 00000000 0 0
00000114 402202b3 1 1 05 00000008 0 00000000 0 0
00000118 00409333 1 1 06 000000a0 0 00000000 0 0
0000011c 005123b3 1 1 07 00000001 0 00000000 0 0
00000120 0033c433 1 1 08 12345001 0 00000000 0 0
00000124 00001497 1 1 09 00001124 0 00000000 0 0
00000128 0100056f 1 1 0a 0000012c 1 00000138 0 0
0000012c 00100593 0 0 00 00000000 0 00000000 0 0
00000138 00608667 1 1 0c 0000013c 1 0000000a 0 0
0000013c 00200693 0 0 00 00000000 0 00000000 0 0
00000200 00408463 1 0 00 00000000 1 00000208 0 0
00000204 00300713 0 0 00 00000000 0 00000000 0 0
00000208 00409463 1 0 00 00000000 0 00000000 0 0
0000020c fe114ce3 1 0 00 00000000 1 00000204 0 0
00000210 00100593 0 0 00 00000000 0 00000000 0 0
00000214 00115463 1 0 00 00000000 0 00000000 0 0
00000218 0020e663 1 0 00 00000000 1 00000224 0 0
0000021c 00200693 0 0 00 00000000 0 00000000 0 0
00000224 0020f463 1 0 00 00000000 0 00000000 0 0
00000228 ffffffff 1 0 00 00000000 0 00000000 1 2
0000022c 00100073 1 0 00 00000000 0 00000000 1 3
00000230 00000073 1 0 00 00000000 0 00000000 1 b
00000234 40109093 1 0 00 00000000 0 00000000 1 2
00000238 009087b3 1 1 0f 00001129 0 00000000 0 0

/* build.f */
rv_pkg.sv
rv_stage_if.sv
rv_decoder.sv
rv_regfile.sv
rv_decode_stage.sv
rv_execute_stage.sv
rv_core_top.sv
rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with verilator, pass or fail comes from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module rv_core_tb \
    -o rv_core_sim > sim.log 2>&1 \
    && ./obj_dir/rv_core_sim >> sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "^Simulation finished: PASS$" sim.log && exit 0 || exit 1
